/* bpu.f */
verilog/bpu_pkg.sv
verilog/bpu_ctrl.sv
verilog/bpu_btb.sv
verilog/bpu_bht.sv
verilog/bpu_pht.sv
verilog/bpu_ras.sv
verilog/bpu.sv
verification/bpu_tb_clk.sv
verification/bpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the predictor testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module bpu_tb -Mdir obj_dir -o bpu_sim -f bpu.f

# the verdict comes from the printed pass line
out=$(./obj_dir/bpu_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
else
    exit 1
fi

/* verification/bpu_tb.sv */
//////////////////////////////////////////////////
// testbench for the branch predictor
// drives fetch, flush and backend corrections, keeps
// a shadow model of the tables and the RAS, and checks
// every packet against it with concurrent assertions
//////////////////////////////////////////////////
`timescale 1ns/1ps

module bpu_tb import bpu_pkg::*; ();

    localparam int TEST_STEPS  = 64;                        // all drive steps, rounded up
    localparam int WATCHDOG_NS = (TEST_STEPS * 40 + 100) * 8;

    logic                clk;
    logic                rst_n;
    logic                flush;
    addr_t               redir_addr;
    correct_info_t [1:0] correct_infos;
    logic                fetch_ready;
    logic                pred_valid;
    bpu_packet_t         pred;

    // shadow tables, row = {bank, index}
    btb_entry_t  btb_m [1024];
    history_t    bht_m [1024];
    scnt_t       pht_m [16384];
    addr_t       ras_m [8];
    ras_ptr_t    m_top;
    ras_ptr_t    m_wptr;
    addr_t       exp_pc;
    bpu_packet_t exp_pkt;   // what the DUT should show this cycle

    integer seed = 32'h8e4d_85fb;
    string  test_name = "reset";
    int     fail_count = 0;
    int     fails_before = 0;
    int     pass_tests = 0;
    int     fail_tests = 0;

    bpu_tb_clk u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    bpu UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush_i         (flush),
        .redir_addr_i    (redir_addr),
        .correct_infos_i (correct_infos),
        .fetch_ready_i   (fetch_ready),
        .pred_valid_o    (pred_valid),
        .pred_o          (pred)
    );

    function automatic logic [9:0] table_row(input logic bank, input addr_t pc);
        return {bank, pc[17:9] ^ pc[11:3]}; // folded btb/bht index
    endfunction

    function automatic scnt_t counter_after(input scnt_t c, input logic taken);
        if (taken) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    function automatic bpu_packet_t predict(input addr_t pc);
        bpu_packet_t pk;
        btb_entry_t  e;
        history_t    h;
        scnt_t       c;
        logic        hit;
        addr_t       fall;
        addr_t       base;
        base = {pc[31:3], 3'b000}; // group base
        for (int i = 0; i < 2; i++) begin
            e    = btb_m[table_row(i[0], pc)];
            h    = bht_m[table_row(i[0], pc)];
            c    = pht_m[{i[0], h, pc[10:3]}]; // slot's own history picks the counter
            hit  = e.is_branch && (e.tag == pc[16:12]);
            fall = (i == 0) ? base + 32'd4 : base + 32'd8;
            pk.predict_infos[i].is_branch   = e.is_branch;
            pk.predict_infos[i].br_type     = e.br_type;
            pk.predict_infos[i].taken       = hit && (e.br_type != BR_NORMAL || c[1]);
            pk.predict_infos[i].target_pc   = (e.br_type == BR_RET) ? ras_m[m_top] : e.target_pc;
            pk.predict_infos[i].next_pc     = pk.predict_infos[i].taken
                                            ? pk.predict_infos[i].target_pc : fall;
            pk.predict_infos[i].scnt        = c;
            pk.predict_infos[i].need_update = !hit;
            pk.predict_infos[i].history     = h;
        end
        pk.pc      = pc;
        pk.mask[0] = !pc[2];
        pk.mask[1] = !pk.predict_infos[0].taken || pc[2];
        return pk;
    endfunction

    function automatic addr_t chosen_next(input bpu_packet_t pk);
        if (pk.predict_infos[0].taken && !pk.pc[2]) begin
            return pk.predict_infos[0].next_pc;
        end
        if (pk.predict_infos[1].taken) begin
            return pk.predict_infos[1].next_pc;
        end
        return {pk.pc[31:3], 3'b000} + 32'd8;
    endfunction

    function automatic void apply_correction(input correct_info_t c);
        logic [9:0]  row;
        logic [13:0] prow;
        btb_entry_t  e;
        if (!c.update) begin
            return;
        end
        row  = table_row(c.pc[2], c.pc);
        prow = {c.pc[2], c.history, c.pc[10:3]};
        if (c.type_miss || c.target_miss) begin
            e.is_branch = c.is_branch;
            e.br_type   = c.branch_type;
            e.tag       = c.pc[16:12];
            e.target_pc = c.target_pc;
            btb_m[row]  = e;
        end
        bht_m[row]  = c.type_miss ? history_t'(c.taken) : {c.history[3:0], c.taken};
        pht_m[prow] = counter_after(c.scnt, c.taken);
        if (c.branch_type == BR_CALL) begin
            ras_m[m_wptr] = c.pc + 32'd4;
            m_top         = m_wptr;
            m_wptr        = m_wptr + 3'd1;
        end else if (c.branch_type == BR_RET) begin
            m_wptr = m_top;
            m_top  = m_top - 3'd1;
        end
    endfunction

    function automatic correct_info_t branch_record(input addr_t pc, input addr_t tgt,
                                                    input br_type_e t, input logic taken,
                                                    input logic type_miss, input scnt_t s,
                                                    input history_t h);
        correct_info_t c;
        c             = '0;
        c.update      = 1'b1;
        c.pc          = pc;
        c.target_pc   = tgt;
        c.is_branch   = 1'b1;
        c.branch_type = t;
        c.taken       = taken;
        c.type_miss   = type_miss;
        c.scnt        = s;
        c.history     = h;
        return c;
    endfunction

    function automatic addr_t rand_addr();
        addr_t a;
        a      = $random(seed);
        a[1:0] = 2'b00; // word aligned
        return a;
    endfunction

    initial begin
        for (int j = 0; j < 1024; j++) begin
            btb_m[j] = '0;
            bht_m[j] = '0;
        end
        for (int j = 0; j < 16384; j++) begin
            pht_m[j] = '0;
        end
        for (int j = 0; j < 8; j++) begin
            ras_m[j] = '0;
        end
    end

    // model steps on the same edge as the DUT, old table state picks the next pc
    always @(posedge clk) begin : model_step
        correct_info_t sel;
        addr_t         nxt;
        if (!rst_n) begin
            m_top  = '1;
            m_wptr = '0;
            exp_pc = BPU_INIT_PC;
        end else begin
            nxt = chosen_next(exp_pkt);
            sel = correct_infos[0].update ? correct_infos[0] : correct_infos[1];
            apply_correction(sel);
            if (flush) begin
                exp_pc = redir_addr;
            end else if (fetch_ready) begin
                exp_pc = nxt;
            end
        end
        exp_pkt = predict(exp_pc);
    end

    // checks at mid cycle, packet is settled there
    a_invalid_in_reset: assert property (@(negedge clk) !rst_n |-> !pred_valid)
        else begin
            fail_count++;
            $display("%s: packet offered while reset is held", test_name);
        end
    a_valid: assert property (@(negedge clk) disable iff (!rst_n) pred_valid)
        else begin
            fail_count++;
            $display("%s: no packet offered out of reset", test_name);
        end
    a_pc: assert property (@(negedge clk) disable iff (!rst_n) pred.pc == exp_pkt.pc)
        else begin
            fail_count++;
            $display("FAILED %s pc: expected %h, actual %h", test_name, exp_pkt.pc, pred.pc);
        end
    a_mask: assert property (@(negedge clk) disable iff (!rst_n) pred.mask == exp_pkt.mask)
        else begin
            fail_count++;
            $display("FAILED %s mask: expected %b, actual %b", test_name, exp_pkt.mask, pred.mask);
        end
    a_slot0: assert property (@(negedge clk) disable iff (!rst_n)
                              pred.predict_infos[0] == exp_pkt.predict_infos[0])
        else begin
            fail_count++;
            $display("FAILED %s slot 0: expected %h, actual %h", test_name,
                     exp_pkt.predict_infos[0], pred.predict_infos[0]);
        end
    a_slot1: assert property (@(negedge clk) disable iff (!rst_n)
                              pred.predict_infos[1] == exp_pkt.predict_infos[1])
        else begin
            fail_count++;
            $display("FAILED %s slot 1: expected %h, actual %h", test_name,
                     exp_pkt.predict_infos[1], pred.predict_infos[1]);
        end

    // one cycle of inputs, set right after the rising edge
    task automatic drive(input logic fl, input addr_t addr, input logic ready,
                         input correct_info_t c0, input correct_info_t c1);
        @(posedge clk);
        flush            <= fl;
        redir_addr       <= addr;
        fetch_ready      <= ready;
        correct_infos[0] <= c0;
        correct_infos[1] <= c1;
    endtask

    task automatic fetch(input int n, input logic ready);
        repeat (n) drive(1'b0, '0, ready, '0, '0);
    endtask

    task automatic redirect(input addr_t a);
        drive(1'b1, a, 1'b1, '0, '0);
    endtask

    // flush back to p with each record so the new counter is read at once
    task automatic counter_run(input addr_t p, input history_t h, input logic taken,
                               input int n, input scnt_t start);
        scnt_t rec;
        rec = start;
        for (int k = 0; k < n; k++) begin
            drive(1'b1, p, 1'b1, branch_record(p, '0, BR_NORMAL, taken, 1'b0, rec, h), '0);
            rec = counter_after(rec, taken); // what the backend sees next time
        end
    endtask

    task automatic report(input int num);
        drive(1'b0, '0, 1'b0, '0, '0); // quiet, pc holds
        @(posedge clk);
        @(negedge clk);
        #1;
        if (fail_count == fails_before) begin
            pass_tests++;
            $display("test %0d %s: ok", num, test_name);
        end else begin
            fail_tests++;
            $display("test %0d %s: %0d check(s) failed", num, test_name,
                     fail_count - fails_before);
        end
        fails_before = fail_count;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: tests still running after %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : stimulus
        addr_t         p;
        addr_t         t;
        correct_info_t skipped;
        flush         = 1'b0;
        redir_addr    = '0;
        correct_infos = '0;
        fetch_ready   = 1'b0;
        wait (pred_valid); // first packet after reset

        test_name = "sequential fetch";
        fetch(6, 1'b1);
        fetch(3, 1'b0);    // back-pressure, pc holds
        fetch(2, 1'b1);
        report(1);

        test_name = "flush and mask";
        p    = rand_addr();
        p[2] = 1'b1;       // only slot 1 valid
        redirect(p);
        fetch(2, 1'b1);
        report(2);

        test_name = "jump training";
        for (int k = 0; k < 2; k++) begin
            p    = rand_addr();
            p[2] = k[0];   // one per bank
            t    = rand_addr();
            drive(1'b0, '0, 1'b0, branch_record(p, t, BR_JUMP, 1'b1, 1'b1, 2'd0, '0), '0);
            redirect(p);
            fetch(2, 1'b1);
        end
        report(3);

        test_name = "counter saturation";
        p    = rand_addr();
        p[2] = 1'b0;
        drive(1'b0, '0, 1'b0, branch_record(p, '0, BR_NORMAL, 1'b1, 1'b1, 2'd0, '0), '0);
        counter_run(p, 5'b11111, 1'b1, 5, 2'd0); // up to 3 and stays
        counter_run(p, 5'b00000, 1'b1, 3, 2'd1);
        counter_run(p, 5'b00000, 1'b0, 5, 2'd3); // down to 0 and stays
        report(4);

        test_name = "call and return";
        for (int k = 0; k < 3; k++) begin
            drive(1'b0, '0, 1'b0,
                  branch_record(rand_addr(), rand_addr(), BR_CALL, 1'b1, 1'b1, 2'd0, '0), '0);
        end
        p = rand_addr();
        drive(1'b0, '0, 1'b0, branch_record(p, '0, BR_RET, 1'b1, 1'b1, 2'd0, '0), '0);
        redirect(p);
        fetch(1, 1'b1);
        drive(1'b0, '0, 1'b0, branch_record(p, '0, BR_RET, 1'b1, 1'b0, 2'd0, '0), '0);
        redirect(p);       // older call now on top
        fetch(1, 1'b1);
        report(5);

        test_name = "slot priority";
        p    = rand_addr();
        p[2] = 1'b0;
        drive(1'b0, '0, 1'b0, branch_record(p, rand_addr(), BR_JUMP, 1'b1, 1'b1, 2'd0, '0), '0);
        drive(1'b0, '0, 1'b0,
              branch_record(p | 32'd4, rand_addr(), BR_JUMP, 1'b1, 1'b1, 2'd0, '0), '0);
        redirect(p);       // both slots taken, slot 0 wins
        fetch(1, 1'b1);
        skipped        = branch_record(p, rand_addr(), BR_JUMP, 1'b1, 1'b1, 2'd0, '0);
        skipped.update = 1'b0;
        t              = rand_addr();
        drive(1'b0, '0, 1'b0, skipped,
              branch_record(t, rand_addr(), BR_JUMP, 1'b1, 1'b1, 2'd0, '0));
        redirect(p);       // slot 0 target unchanged
        fetch(1, 1'b1);
        redirect(t);       // second record was the one written
        fetch(1, 1'b1);
        report(6);

        $display("tests passed %0d, failed %0d, failed checks %0d",
                 pass_tests, fail_tests, fail_count);
        if (fail_count == 0 && fail_tests == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* verification/bpu_tb_clk.sv */
//////////////////////////////////////////////////
// testbench clock and reset for the predictor
// 8 ns clock, rst_n low for the first 3 rising edges
//////////////////////////////////////////////////
`timescale 1ns/1ps

module bpu_tb_clk (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o; // half period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        rst_n_o <= 1'b1; // released on the edge, like any input
    end

endmodule

/* verilog/bpu.sv */
//////////////////////////////////////////////////
// branch predictor top level
// one two-slot prediction packet per cycle from the
// current fetch pc; backend corrections train the
// btb, bht, pht and ras through the control block
//////////////////////////////////////////////////
`timescale 1ns/1ps

module bpu import bpu_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush_i,
    input  addr_t               redir_addr_i,
    input  correct_info_t [1:0] correct_infos_i, // up to two per cycle
    input  logic                fetch_ready_i,
    output logic                pred_valid_o,
    output bpu_packet_t         pred_o
);

    addr_t            pc;
    correct_info_t    correct_sel; // record applied this cycle
    btb_entry_t [1:0] btb_rdata;
    logic [1:0]       btb_hit;
    history_t [1:0]   hist;
    scnt_t [1:0]      scnt;
    addr_t            ras_top;

    bpu_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush_i         (flush_i),
        .redir_addr_i    (redir_addr_i),
        .correct_infos_i (correct_infos_i),
        .fetch_ready_i   (fetch_ready_i),
        .btb_rdata_i     (btb_rdata),
        .btb_hit_i       (btb_hit),
        .hist_i          (hist),
        .scnt_i          (scnt),
        .ras_top_i       (ras_top),
        .pc_o            (pc),
        .correct_sel_o   (correct_sel),
        .pred_valid_o    (pred_valid_o),
        .pred_o          (pred_o)
    );

    bpu_btb u_btb (
        .clk       (clk),
        .pc_i      (pc),
        .correct_i (correct_sel),
        .rdata_o   (btb_rdata),
        .hit_o     (btb_hit)
    );

    bpu_bht u_bht (
        .clk       (clk),
        .pc_i      (pc),
        .correct_i (correct_sel),
        .hist_o    (hist)
    );

    // pattern index per slot comes from that slot's history
    bpu_pht u_pht (
        .clk       (clk),
        .pc_i      (pc),
        .hist_i    (hist),
        .correct_i (correct_sel),
        .scnt_o    (scnt)
    );

    bpu_ras u_ras (
        .clk       (clk),
        .rst_n     (rst_n),
        .correct_i (correct_sel),
        .top_o     (ras_top)
    );

endmodule

/* verilog/bpu_ras.sv */
//////////////////////////////////////////////////
// return address stack, trained by the backend
// resolved calls push pc + 4, resolved returns pop
// top_o is the predicted return target
//////////////////////////////////////////////////
`timescale 1ns/1ps

module bpu_ras import bpu_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  correct_info_t correct_i,
    output addr_t         top_o
);

    addr_t    stack [BPU_RAS_DEPTH];
    ras_ptr_t top_ptr; // newest entry
    ras_ptr_t w_ptr;   // slot above top
    logic     push;
    logic     pop;

    initial begin
        for (int j = 0; j < BPU_RAS_DEPTH; j++) begin
            stack[j] = '0;
        end
    end

    assign push = correct_i.update & (correct_i.branch_type == BR_CALL);
    assign pop  = correct_i.update & (correct_i.branch_type == BR_RET);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_ptr <= '1;
            w_ptr   <= '0;
        end else if (push) begin
            top_ptr <= w_ptr;
            w_ptr   <= w_ptr + 1'b1; // wraps, oldest entry overwritten
        end else if (pop) begin
            w_ptr   <= top_ptr;
            top_ptr <= top_ptr - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            stack[w_ptr] <= correct_i.pc + 32'd4;
        end
    end

    assign top_o = stack[top_ptr];

    a_no_push_pop: assert property (@(posedge clk) disable iff (!rst_n) !(push && pop))
        else $error("bpu_ras: call and return in one record");

endmodule

/* verilog/bpu_pht.sv */
//////////////////////////////////////////////////
// pattern history table of 2-bit counters
// two banks, each read at {slot history, pc[10:3]};
// one write port trains the counter recorded in the
// backend correction, bank from pc[2]
//////////////////////////////////////////////////
`timescale 1ns/1ps

module bpu_pht import bpu_pkg::*; (
    input  logic           clk,
    input  addr_t          pc_i,
    input  history_t [1:0] hist_i,
    input  correct_info_t  correct_i,
    output scnt_t [1:0]    scnt_o
);

    scnt_t mem [2][BPU_PHT_DEPTH];

    pht_idx_t [1:0] ridx; // differs per slot, each has its own history
    pht_idx_t       widx;
    scnt_t          wdata;

    initial begin
        for (int b = 0; b < 2; b++) begin
            for (int j = 0; j < BPU_PHT_DEPTH; j++) begin
                mem[b][j] = 2'b00; // strongly not taken
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            ridx[i]   = {hist_i[i], pc_i[BPU_PHT_PC_LEN+3-1:3]};
            scnt_o[i] = mem[i][ridx[i]];
        end
    end

    // train from the values seen at predict time, not a fresh read
    assign widx  = {correct_i.history, correct_i.pc[BPU_PHT_PC_LEN+3-1:3]};
    assign wdata = next_scnt(correct_i.scnt, correct_i.taken);

    always_ff @(posedge clk) begin
        if (correct_i.update) begin
            mem[correct_i.pc[2]][widx] <= wdata;
        end
    end

endmodule

/* verilog/bpu_bht.sv */
//////////////////////////////////////////////////
// local history table, two banks at the btb index
// every backend update shifts in the resolved
// direction; a type miss restarts the history
//////////////////////////////////////////////////
`timescale 1ns/1ps

module bpu_bht import bpu_pkg::*; (
    input  logic           clk,
    input  addr_t          pc_i,
    input  correct_info_t  correct_i,
    output history_t [1:0] hist_o
);

    history_t mem [2][BPU_BTB_DEPTH];

    btb_idx_t ridx;
    btb_idx_t widx;
    history_t wdata;

    initial begin
        for (int b = 0; b < 2; b++) begin
            for (int j = 0; j < BPU_BTB_DEPTH; j++) begin
                mem[b][j] = '0;
            end
        end
    end

    assign ridx = btb_hash(pc_i);  // same index as the btb
    assign widx = btb_hash(correct_i.pc);

    assign hist_o[0] = mem[0][ridx];
    assign hist_o[1] = mem[1][ridx];

    // new branch at this index -> history starts over
    assign wdata = correct_i.type_miss
                 ? {{(BPU_HISTORY_LEN-1){1'b0}}, correct_i.taken}
                 : {correct_i.history[BPU_HISTORY_LEN-2:0], correct_i.taken};

    always_ff @(posedge clk) begin
        if (correct_i.update) begin
            mem[correct_i.pc[2]][widx] <= wdata;
        end
    end

endmodule

/* verilog/bpu_btb.sv */
//////////////////////////////////////////////////
// branch target buffer, two banks (one per slot)
// both banks read at the hashed fetch pc with a tag
// compare; the backend correction rewrites an entry
// on a type or target miss, bank from pc[2]
//////////////////////////////////////////////////
`timescale 1ns/1ps

module bpu_btb import bpu_pkg::*; (
    input  logic             clk,
    input  addr_t            pc_i,
    input  correct_info_t    correct_i,
    output btb_entry_t [1:0] rdata_o,
    output logic [1:0]       hit_o
);

    btb_entry_t mem [2][BPU_BTB_DEPTH]; // bank 0 = slot 0, bank 1 = slot 1

    btb_idx_t   ridx;
    btb_idx_t   widx;
    btb_tag_t   rtag;
    btb_entry_t wentry;
    logic       we;

    initial begin
        for (int b = 0; b < 2; b++) begin
            for (int j = 0; j < BPU_BTB_DEPTH; j++) begin
                mem[b][j] = '0;
            end
        end
    end

    assign ridx = btb_hash(pc_i);
    assign rtag = btb_get_tag(pc_i);

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rdata_o[i] = mem[i][ridx]; // async read
            // empty entries have is_branch low, so no false hit on zeroed tags
            hit_o[i]   = (rdata_o[i].tag == rtag) & rdata_o[i].is_branch;
        end
    end

    assign widx = btb_hash(correct_i.pc);
    // only rewrite when the stored entry was wrong
    assign we   = correct_i.update & (correct_i.type_miss | correct_i.target_miss);

    always_comb begin
        wentry.is_branch = correct_i.is_branch;
        wentry.br_type   = correct_i.branch_type;
        wentry.tag       = btb_get_tag(correct_i.pc);
        wentry.target_pc = correct_i.target_pc;
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[correct_i.pc[2]][widx] <= wentry; // slot of the branch picks the bank
        end
    end

endmodule

/* verilog/bpu_ctrl.sv */
//////////////////////////////////////////////////
// predictor control
// holds the fetch pc, picks the correction record sent
// to the tables, decides per-slot branches from the
// table reads and assembles the prediction packet
// everything after the pc register is combinational
//////////////////////////////////////////////////
`timescale 1ns/1ps

module bpu_ctrl import bpu_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush_i,
    input  addr_t               redir_addr_i,
    input  correct_info_t [1:0] correct_infos_i,
    input  logic                fetch_ready_i,
    input  btb_entry_t [1:0]    btb_rdata_i,
    input  logic [1:0]          btb_hit_i,
    input  history_t [1:0]      hist_i,
    input  scnt_t [1:0]         scnt_i,
    input  addr_t               ras_top_i,
    output addr_t               pc_o,
    output correct_info_t       correct_sel_o,
    output logic                pred_valid_o,
    output bpu_packet_t         pred_o
);

    addr_t        pc;
    addr_t        pc_next;     // next group to fetch
    addr_t        pc_add_8;    // next aligned group
    addr_t        slot0_fall;  // base + 4
    logic [1:0]   branch;      // slot leaves the straight line
    logic [1:0]   mask;
    addr_t [1:0]  target_pc;
    addr_t [1:0]  next_pc;

    // first record with update set wins
    assign correct_sel_o = correct_infos_i[0].update ? correct_infos_i[0] : correct_infos_i[1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= BPU_INIT_PC;
        end else if (flush_i) begin
            pc <= redir_addr_i; // redirect has priority over prediction
        end else if (fetch_ready_i) begin
            pc <= pc_next;
        end
    end

    assign pc_add_8   = {pc[31:3] + 29'd1, 3'b000};
    assign slot0_fall = {pc[31:3], 3'b100};

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            // unconditional types always go, conditional follow counter msb
            branch[i]    = btb_hit_i[i] & ((btb_rdata_i[i].br_type != BR_NORMAL) | scnt_i[i][1]);
            target_pc[i] = (btb_rdata_i[i].br_type == BR_RET) ? ras_top_i
                                                              : btb_rdata_i[i].target_pc;
        end
        next_pc[0] = branch[0] ? target_pc[0] : slot0_fall;
        next_pc[1] = branch[1] ? target_pc[1] : pc_add_8;
    end

    always_comb begin
        pc_next = pc_add_8;
        if (branch[0] && !pc[2]) begin
            pc_next = next_pc[0]; // slot 0 only exists on an aligned pc
        end else if (branch[1]) begin
            pc_next = next_pc[1];
        end
    end

    // slot 1 dropped when slot 0 branches away
    assign mask = {~branch[0] | pc[2], ~pc[2]};

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            pred_o.predict_infos[i].target_pc   = target_pc[i];
            pred_o.predict_infos[i].next_pc     = next_pc[i];
            pred_o.predict_infos[i].is_branch   = btb_rdata_i[i].is_branch;
            pred_o.predict_infos[i].br_type     = btb_rdata_i[i].br_type;
            pred_o.predict_infos[i].taken       = branch[i];
            pred_o.predict_infos[i].scnt        = scnt_i[i];
            pred_o.predict_infos[i].need_update = ~btb_hit_i[i]; // miss -> backend trains
            pred_o.predict_infos[i].history     = hist_i[i];
        end
        pred_o.pc   = pc;
        pred_o.mask = mask;
    end

    assign pc_o         = pc;
    assign pred_valid_o = rst_n; // a packet is ready every cycle out of reset

    // one packet per cycle, no bubbles once reset is released
    a_valid_out_of_reset: assert property (@(posedge clk) rst_n |-> pred_valid_o)
        else $error("bpu_ctrl: packet not valid out of reset");

endmodule

/* verilog/bpu_pkg.sv */
//////////////////////////////////////////////////
// shared definitions for the branch predictor
// widths, table types, branch types, correction and
// prediction records, plus the index/tag/counter
// helpers used by the tables and the control logic
//////////////////////////////////////////////////
package bpu_pkg;

    localparam logic [31:0] BPU_INIT_PC = 32'h1c00_0000; // fetch address after reset

    localparam int BPU_BTB_LEN     = 9;  // btb / bht index width
    localparam int BPU_BTB_DEPTH   = 1 << BPU_BTB_LEN;
    localparam int BPU_TAG_LEN     = 5;  // tag from pc[16:12]
    localparam int BPU_HISTORY_LEN = 5;  // local history bits
    localparam int BPU_PHT_PC_LEN  = 8;  // pc[10:3] in pattern index
    localparam int BPU_PHT_LEN     = BPU_HISTORY_LEN + BPU_PHT_PC_LEN;
    localparam int BPU_PHT_DEPTH   = 1 << BPU_PHT_LEN;
    localparam int BPU_RAS_LEN     = 3;  // stack pointer width
    localparam int BPU_RAS_DEPTH   = 1 << BPU_RAS_LEN;

    typedef logic [31:0]                addr_t;
    typedef logic [BPU_BTB_LEN-1:0]     btb_idx_t;
    typedef logic [BPU_TAG_LEN-1:0]     btb_tag_t;
    typedef logic [BPU_HISTORY_LEN-1:0] history_t;
    typedef logic [BPU_PHT_LEN-1:0]     pht_idx_t;
    typedef logic [1:0]                 scnt_t;    // 2-bit saturating counter
    typedef logic [BPU_RAS_LEN-1:0]     ras_ptr_t;

    typedef enum logic [1:0] {
        BR_NORMAL = 2'd0, // conditional
        BR_JUMP   = 2'd1, // unconditional, direct
        BR_CALL   = 2'd2,
        BR_RET    = 2'd3
    } br_type_e;

    typedef struct packed {
        logic     is_branch;
        br_type_e br_type;
        btb_tag_t tag;
        addr_t    target_pc;
    } btb_entry_t;

    // one resolved branch from the backend
    typedef struct packed {
        logic     update;      // record is meaningful
        addr_t    pc;
        addr_t    target_pc;
        logic     is_branch;
        br_type_e branch_type;
        logic     taken;       // resolved direction
        logic     type_miss;
        logic     target_miss;
        scnt_t    scnt;        // counter seen at predict time
        history_t history;     // history seen at predict time
    } correct_info_t;

    typedef struct packed {
        addr_t    target_pc;
        addr_t    next_pc;
        logic     is_branch;
        br_type_e br_type;
        logic     taken;
        scnt_t    scnt;
        logic     need_update; // no btb entry for this slot
        history_t history;
    } predict_info_t;

    typedef struct packed {
        predict_info_t [1:0] predict_infos;
        addr_t               pc;   // group pc as fetched
        logic [1:0]          mask; // valid slots in the group
    } bpu_packet_t;

    // folds pc[17:9] onto pc[11:3], tied to BPU_BTB_LEN == 9
    function automatic btb_idx_t btb_hash(input addr_t pc);
        return pc[17:9] ^ pc[11:3];
    endfunction

    function automatic btb_tag_t btb_get_tag(input addr_t pc);
        return pc[BPU_TAG_LEN+12-1:12];
    endfunction

    // one step toward 3 when taken, toward 0 when not
    function automatic scnt_t next_scnt(input scnt_t last, input logic taken);
        case (last)
            2'b00:   return {1'b0, taken};  // strongly not taken
            2'b01:   return {taken, 1'b0};  // weakly not taken
            2'b10:   return {taken, 1'b1};  // weakly taken
            default: return {1'b1, taken};  // strongly taken
        endcase
    endfunction

endpackage
